//--- common/clint_params.svh
/*
 * Build-time configuration of the core-local interrupt controller.
 * Included by the packages and by every module that needs a size or
 * an address constant.
 */
`ifndef CLINT_PARAMS_SVH
`define CLINT_PARAMS_SVH

`define CLINT_NUM_HARTS     4
`define CLINT_DATA_W        32
`define CLINT_ADDR_W        16
`define CLINT_TIME_W        64
`define CLINT_SYNC_STAGES   2

// Byte addresses of the register banks
`define CLINT_MSIP_BASE     16'h0000
`define CLINT_MTIMECMP_BASE 16'h4000
`define CLINT_MTIME_BASE    16'hBFF8

`endif

//--- common/clint_bus_pkg.sv
/*
 * Register bus types and the decoded address map of the CLINT.
 * Imported by the register file and the top level.
 */
`include "clint_params.svh"

package clint_bus_pkg;

    typedef logic [`CLINT_ADDR_W-1:0] bus_addr_t;
    typedef logic [`CLINT_DATA_W-1:0] bus_data_t;

    // Register kind selected by a bus address
    typedef enum logic [2:0] {
        SEL_MSIP,
        SEL_CMP_LO,
        SEL_CMP_HI,
        SEL_MTIME_LO,
        SEL_MTIME_HI,
        SEL_NONE
    } reg_sel_e;

    // ----------------------------------------------------------------------
    // Address map
    // ----------------------------------------------------------------------
    parameter bus_addr_t MSIP_BASE     = `CLINT_MSIP_BASE;
    parameter bus_addr_t MTIMECMP_BASE = `CLINT_MTIMECMP_BASE;

    // One word per hart for msip, two words per hart for mtimecmp
    parameter bus_addr_t MSIP_SPAN     = bus_addr_t'(4 * `CLINT_NUM_HARTS);
    parameter bus_addr_t CMP_SPAN      = bus_addr_t'(8 * `CLINT_NUM_HARTS);

    parameter bus_addr_t MTIME_LO_ADDR = `CLINT_MTIME_BASE;
    parameter bus_addr_t MTIME_HI_ADDR = bus_addr_t'(`CLINT_MTIME_BASE + 4);

endpackage

//--- common/clint_hart_pkg.sv
/*
 * Per-hart vector and timer value types.
 * Shared by the register file, the comparator and the checker.
 */
`include "clint_params.svh"

package clint_hart_pkg;

    // One bit per hart, bit n belongs to hart n
    typedef logic [`CLINT_NUM_HARTS-1:0] hart_vec_t;

    typedef logic [`CLINT_TIME_W-1:0] time_t;

    // Compare values of all harts
    typedef time_t [`CLINT_NUM_HARTS-1:0] cmp_array_t;

endpackage

//--- logic/clint_rtc_sync.sv
/*
 * Brings the slow real-time clock into the core clock domain and
 * emits a single-cycle tick for every rising edge of it. The tick
 * follows the edge by STAGES + 1 cycles.
 */
`timescale 1ns/1ns
`include "clint_params.svh"

module clint_rtc_sync #(
    parameter int unsigned STAGES = `CLINT_SYNC_STAGES
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic rtc_i,
    output logic tick_o
);

    logic [STAGES-1:0] sync_q;
    logic              level_q;
    logic              tick_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q  <= '0;
            level_q <= 1'b0;
            tick_q  <= 1'b0;
        end else begin
            sync_q  <= {sync_q[STAGES-2:0], rtc_i};
            level_q <= sync_q[STAGES-1];
            // Rising edge of the synchronized level
            tick_q  <= sync_q[STAGES-1] & ~level_q;
        end
    end

    assign tick_o = tick_q;

endmodule

//--- regfile/clint_regfile.sv
/*
 * CLINT register file. Decodes the valid/ready register bus, holds
 * mtime, the per-hart mtimecmp registers and the msip bits, and
 * returns one registered response per accepted request. mtime counts
 * RTC ticks; a bus write to it wins over a tick in the same cycle.
 */
`timescale 1ns/1ns
`include "clint_params.svh"

module clint_regfile import clint_bus_pkg::*, clint_hart_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       tick_i,
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  logic       req_write_i,
    input  bus_addr_t  req_addr_i,
    input  bus_data_t  req_wdata_i,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,
    output bus_data_t  rsp_rdata_o,
    output logic       rsp_err_o,
    output time_t      mtime_o,
    output cmp_array_t mtimecmp_o,
    output hart_vec_t  msip_o
);

    localparam int unsigned HART_IDX_W =
        (`CLINT_NUM_HARTS > 1) ? $clog2(`CLINT_NUM_HARTS) : 1;

    reg_sel_e              sel;
    logic [HART_IDX_W-1:0] hart_idx;
    bus_addr_t             msip_off;
    bus_addr_t             cmp_off;
    bus_data_t             rdata;
    logic                  req_fire;
    logic                  wr_en;

    time_t                 mtime_q;
    cmp_array_t            mtimecmp_q;
    hart_vec_t             msip_q;
    logic                  rsp_valid_q;
    logic                  rsp_err_q;
    bus_data_t             rsp_rdata_q;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------
    assign msip_off = req_addr_i - MSIP_BASE;
    assign cmp_off  = req_addr_i - MTIMECMP_BASE;

    always_comb begin
        sel      = SEL_NONE;
        hart_idx = '0;
        // Only word-aligned addresses map to a register
        if (req_addr_i[1:0] == 2'b00) begin
            if (msip_off < MSIP_SPAN) begin
                sel      = SEL_MSIP;
                hart_idx = msip_off[HART_IDX_W+1:2];
            end else if (cmp_off < CMP_SPAN) begin
                sel      = cmp_off[2] ? SEL_CMP_HI : SEL_CMP_LO;
                hart_idx = cmp_off[HART_IDX_W+2:3];
            end else if (req_addr_i == MTIME_LO_ADDR) begin
                sel = SEL_MTIME_LO;
            end else if (req_addr_i == MTIME_HI_ADDR) begin
                sel = SEL_MTIME_HI;
            end
        end
    end

    always_comb begin
        case (sel)
            SEL_MSIP:     rdata = bus_data_t'(msip_q[hart_idx]);
            SEL_CMP_LO:   rdata = mtimecmp_q[hart_idx][`CLINT_DATA_W-1:0];
            SEL_CMP_HI:   rdata = mtimecmp_q[hart_idx][`CLINT_TIME_W-1:`CLINT_DATA_W];
            SEL_MTIME_LO: rdata = mtime_q[`CLINT_DATA_W-1:0];
            SEL_MTIME_HI: rdata = mtime_q[`CLINT_TIME_W-1:`CLINT_DATA_W];
            default:      rdata = '0;
        endcase
    end

    // One outstanding request, a new one may enter as the old response leaves
    assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
    assign req_fire    = req_valid_i & req_ready_o;
    assign wr_en       = req_fire & req_write_i;

    // ----------------------------------------------------------------------
    // Registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q <= '0;
        end else if (wr_en && sel == SEL_MTIME_LO) begin
            mtime_q[`CLINT_DATA_W-1:0] <= req_wdata_i;
        end else if (wr_en && sel == SEL_MTIME_HI) begin
            mtime_q[`CLINT_TIME_W-1:`CLINT_DATA_W] <= req_wdata_i;
        end else if (tick_i) begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtimecmp_q <= '1;
            msip_q     <= '0;
        end else if (wr_en) begin
            case (sel)
                SEL_MSIP:   msip_q[hart_idx] <= req_wdata_i[0];
                SEL_CMP_LO: mtimecmp_q[hart_idx][`CLINT_DATA_W-1:0] <= req_wdata_i;
                SEL_CMP_HI: mtimecmp_q[hart_idx][`CLINT_TIME_W-1:`CLINT_DATA_W] <= req_wdata_i;
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Response
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
            rsp_err_q   <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
            rsp_err_q   <= (sel == SEL_NONE);
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
            rsp_err_q   <= 1'b0;
        end
    end

    // Writes and unmapped reads answer with zero
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            rsp_rdata_q <= req_write_i ? '0 : rdata;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_err_o   = rsp_err_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign mtime_o     = mtime_q;
    assign mtimecmp_o  = mtimecmp_q;
    assign msip_o      = msip_q;

endmodule

//--- logic/clint_irq_cmp.sv
/*
 * Timer interrupt generation. Each hart's interrupt is high while
 * mtime is at or above that hart's mtimecmp, one cycle after the
 * values it was computed from.
 */
`timescale 1ns/1ns
`include "clint_params.svh"

module clint_irq_cmp import clint_hart_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  time_t      mtime_i,
    input  cmp_array_t mtimecmp_i,
    output hart_vec_t  timer_irq_o
);

    hart_vec_t irq_d;
    hart_vec_t irq_q;

    // Unsigned compare per hart
    always_comb begin
        for (int unsigned i = 0; i < `CLINT_NUM_HARTS; i++) begin
            irq_d[i] = (mtime_i >= mtimecmp_i[i]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_q <= '0;
        end else begin
            irq_q <= irq_d;
        end
    end

    assign timer_irq_o = irq_q;

endmodule

//--- logic/clint_top.sv
/*
 * Top level of the core-local interrupt controller. Chains the RTC
 * synchronizer, the register file and the timer comparator, and
 * exposes the register bus and the per-hart interrupt vectors.
 */
`timescale 1ns/1ns
`include "clint_params.svh"

module clint_top import clint_bus_pkg::*, clint_hart_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      rtc_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  logic      req_write_i,
    input  bus_addr_t req_addr_i,
    input  bus_data_t req_wdata_i,
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i,
    output bus_data_t rsp_rdata_o,
    output logic      rsp_err_o,
    output hart_vec_t timer_irq_o,
    output hart_vec_t ipi_o
);

    logic       tick;
    time_t      mtime;
    cmp_array_t mtimecmp;

    clint_rtc_sync #(
        .STAGES (`CLINT_SYNC_STAGES)
    ) i_rtc_sync (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rtc_i   (rtc_i),
        .tick_o  (tick)
    );

    // msip bits drive the software interrupts directly
    clint_regfile i_regfile (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .tick_i      (tick),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .mtime_o     (mtime),
        .mtimecmp_o  (mtimecmp),
        .msip_o      (ipi_o)
    );

    clint_irq_cmp i_irq_cmp (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mtime_i     (mtime),
        .mtimecmp_i  (mtimecmp),
        .timer_irq_o (timer_irq_o)
    );

endmodule

//--- verification/clint_checker.sv
/*
 * Checker of the CLINT testbench. Watches the bus handshakes of the
 * DUT, compares responses and interrupt vectors with the expected
 * values that the testbench supplies, and counts errors.
 */
`timescale 1ns/1ns
`include "clint_params.svh"

module clint_checker import clint_hart_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_valid_i,
    input  logic                     req_ready_i,
    input  logic                     rsp_valid_i,
    input  logic                     rsp_ready_i,
    input  logic [`CLINT_DATA_W-1:0] rsp_rdata_i,
    input  logic                     rsp_err_i,
    input  hart_vec_t                timer_irq_i,
    input  hart_vec_t                ipi_i,
    input  logic [7:0]               cmd_i,
    input  logic [`CLINT_ADDR_W-1:0] addr_i,
    input  int                       step_i,
    input  logic [`CLINT_DATA_W-1:0] exp_rdata_i,
    input  logic                     exp_err_i,
    input  logic                     irq_strobe_i,
    input  hart_vec_t                exp_timer_i,
    input  hart_vec_t                exp_ipi_i,
    output int                       data_errs_o,
    output int                       proto_errs_o
);

    logic                     accepted;
    logic                     stalled;
    logic [`CLINT_DATA_W-1:0] held_rdata;
    logic                     held_err;
    // Expectation of the outstanding request
    logic [`CLINT_DATA_W-1:0] exp_rdata;
    logic                     exp_err;
    logic [7:0]               req_cmd;
    logic [`CLINT_ADDR_W-1:0] req_addr;
    int                       req_step;

    task automatic compare(input logic [7:0] cmd, input logic [`CLINT_ADDR_W-1:0] addr,
                           input int step, input string what,
                           input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("Fail step %0d (%c %h) %s: expected %0h, actual %0h",
                     step, cmd, addr, what, exp, act);
            data_errs_o++;
        end
    endtask

    task automatic protocol_error(input string msg);
        $display("Protocol error at %0t ns: %s", $time, msg);
        proto_errs_o++;
    endtask

    initial begin
        data_errs_o  = 0;
        proto_errs_o = 0;
    end

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            accepted = 1'b0;
            stalled  = 1'b0;
        end else begin
            if (accepted && !rsp_valid_i) begin
                protocol_error("no response one cycle after the request was accepted");
            end
            if (stalled && !rsp_valid_i) begin
                protocol_error("response withdrawn before it was consumed");
            end
            if (stalled && rsp_valid_i && (rsp_rdata_i !== held_rdata || rsp_err_i !== held_err)) begin
                protocol_error("response changed while the requester stalled it");
            end
            if (rsp_valid_i && !rsp_ready_i && req_ready_i) begin
                protocol_error("request channel ready while a response is pending");
            end
            // Consumption is handled before a new acceptance in the same cycle
            if (rsp_valid_i && rsp_ready_i) begin
                compare(req_cmd, req_addr, req_step, "rdata", exp_rdata, rsp_rdata_i);
                compare(req_cmd, req_addr, req_step, "err", exp_err, rsp_err_i);
            end
            stalled    = rsp_valid_i && !rsp_ready_i;
            held_rdata = rsp_rdata_i;
            held_err   = rsp_err_i;
            accepted   = req_valid_i && req_ready_i;
            if (accepted) begin
                exp_rdata = exp_rdata_i;
                exp_err   = exp_err_i;
                req_cmd   = cmd_i;
                req_addr  = addr_i;
                req_step  = step_i;
            end
            if (irq_strobe_i) begin
                compare(cmd_i, addr_i, step_i, "timer_irq", exp_timer_i, timer_irq_i);
                compare(cmd_i, addr_i, step_i, "ipi", exp_ipi_i, ipi_i);
            end
        end
    end

endmodule

//--- verification/clint_tb.sv
/*
 * Testbench of the CLINT. Reads commands and expected values from the
 * stimulus file, drives the register bus and the RTC input of the DUT
 * on the falling clock edge, and leaves the comparing to clint_checker.
 */
`timescale 1ns/1ns
`include "clint_params.svh"

module clint_tb import clint_bus_pkg::*, clint_hart_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int RTC_HOLD     = 8;
    localparam int IRQ_WAIT     = 8;
    localparam     STIM_FILE    = "verification/clint_stimulus.txt";

    logic      clk = 1'b0;
    logic      rst_n;
    logic      rtc;
    logic      req_valid;
    logic      req_ready;
    logic      req_write;
    bus_addr_t req_addr;
    bus_data_t req_wdata;
    logic      rsp_valid;
    logic      rsp_ready;
    bus_data_t rsp_rdata;
    logic      rsp_err;
    hart_vec_t timer_irq;
    hart_vec_t ipi;

    // Expectations handed to the checker
    logic [7:0] cur_cmd;
    bus_addr_t  cur_addr;
    int         cur_step;
    bus_data_t  exp_rdata;
    logic       exp_err;
    logic       irq_strobe;
    hart_vec_t  exp_timer;
    hart_vec_t  exp_ipi;
    int         data_errs;
    int         proto_errs;
    int         stim_errs;

    // Commands of the stimulus file
    logic [7:0]  cmd_q[$];
    bus_addr_t   addr_q[$];
    bus_data_t   data_q[$];
    bus_data_t   exp_q[$];
    int          rtc_edges;
    int          cycle_cnt;
    int          cycle_limit;
    logic [31:0] rng_state;

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    clint_top dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .rtc_i       (rtc),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_write_i (req_write),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_rdata_o (rsp_rdata),
        .rsp_err_o   (rsp_err),
        .timer_irq_o (timer_irq),
        .ipi_o       (ipi)
    );

    clint_checker chk (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid),
        .req_ready_i  (req_ready),
        .rsp_valid_i  (rsp_valid),
        .rsp_ready_i  (rsp_ready),
        .rsp_rdata_i  (rsp_rdata),
        .rsp_err_i    (rsp_err),
        .timer_irq_i  (timer_irq),
        .ipi_i        (ipi),
        .cmd_i        (cur_cmd),
        .addr_i       (cur_addr),
        .step_i       (cur_step),
        .exp_rdata_i  (exp_rdata),
        .exp_err_i    (exp_err),
        .irq_strobe_i (irq_strobe),
        .exp_timer_i  (exp_timer),
        .exp_ipi_i    (exp_ipi),
        .data_errs_o  (data_errs),
        .proto_errs_o (proto_errs)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Random response back-pressure with about three cycles in eight stalled
    always @(negedge clk) begin
        rng_state = xorshift32(rng_state);
        rsp_ready = (rng_state[2:0] > 3'd2);
    end

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          n;
        int          ch;
        logic [7:0]  c;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen(STIM_FILE, "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            n = $fscanf(fd, " %c", c);
            if (n == 1 && c == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (n == 1) begin
                n = $fscanf(fd, "%h %h %h", a, d, e);
                if (n != 3) begin
                    $display("Malformed stimulus entry after command %0d", cmd_q.size());
                    stim_errs++;
                end
                cmd_q.push_back(c);
                addr_q.push_back(bus_addr_t'(a));
                data_q.push_back(d);
                exp_q.push_back(e);
                if (c == "T") begin
                    rtc_edges += d;
                end
            end
        end
        if (ok) begin
            $fclose(fd);
        end
    endtask

    // Starts on a falling edge, returns once the response is consumed
    task automatic bus_access(input logic wr, input bus_addr_t addr, input bus_data_t wdata,
                              input bus_data_t rdata, input logic err);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        exp_rdata = rdata;
        exp_err   = err;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        @(posedge clk);
        while (!(rsp_valid && rsp_ready)) begin
            @(posedge clk);
        end
    endtask

    task automatic drive_rtc(input int edges);
        for (int n = 0; n < edges; n++) begin
            rtc = 1'b1;
            repeat (RTC_HOLD) @(negedge clk);
            rtc = 1'b0;
            repeat (RTC_HOLD) @(negedge clk);
        end
    endtask

    task automatic expect_irq(input hart_vec_t timer, input hart_vec_t sw);
        repeat (IRQ_WAIT) @(negedge clk);
        exp_timer  = timer;
        exp_ipi    = sw;
        irq_strobe = 1'b1;
        @(negedge clk);
        irq_strobe = 1'b0;
    endtask

    task automatic run_command(input int i);
        @(negedge clk);
        cur_cmd  = cmd_q[i];
        cur_addr = addr_q[i];
        cur_step = i;
        case (cmd_q[i])
            "W": bus_access(1'b1, addr_q[i], data_q[i], '0, 1'b0);
            "R": bus_access(1'b0, addr_q[i], '0, exp_q[i], 1'b0);
            // Unmapped write, then a read of the same address
            "E": begin
                bus_access(1'b1, addr_q[i], data_q[i], '0, 1'b1);
                @(negedge clk);
                bus_access(1'b0, addr_q[i], '0, '0, 1'b1);
            end
            "T": drive_rtc(data_q[i]);
            "I": expect_irq(hart_vec_t'(data_q[i]), hart_vec_t'(exp_q[i]));
            default: begin
                $display("Unknown command '%c' at step %0d", cmd_q[i], i);
                stim_errs++;
            end
        endcase
    endtask

    task automatic finish_run(input bit aborted);
        $display("Errors: %0d data, %0d protocol, %0d stimulus",
                 data_errs, proto_errs, stim_errs);
        if (!aborted && data_errs == 0 && proto_errs == 0 && stim_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        finish_run(1'b1);
    end

    initial begin
        bit loaded;
        rst_n       = 1'b0;
        rtc         = 1'b0;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b1;
        irq_strobe  = 1'b0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        exp_timer   = '0;
        exp_ipi     = '0;
        cur_cmd     = "-";
        cur_addr    = '0;
        cur_step    = 0;
        stim_errs   = 0;
        rtc_edges   = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        rng_state   = 32'd62;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            finish_run(1'b1);
        end else begin
            cycle_limit = 200 + 64 * cmd_q.size() + 20 * rtc_edges;
            repeat (RESET_CYCLES) @(negedge clk);
            rst_n = 1'b1;
            foreach (cmd_q[i]) begin
                run_command(i);
            end
            repeat (4) @(negedge clk);
            finish_run(1'b0);
        end
    end

endmodule

//--- list.f
+incdir+common
common/clint_bus_pkg.sv
common/clint_hart_pkg.sv
logic/clint_rtc_sync.sv
regfile/clint_regfile.sv
logic/clint_irq_cmp.sv
logic/clint_top.sv
verification/clint_checker.sv
verification/clint_tb.sv

//--- Bender.yml
package:
  name: clint

export_include_dirs:
  - common

sources:
  - common/clint_bus_pkg.sv
  - common/clint_hart_pkg.sv
  - logic/clint_rtc_sync.sv
  - regfile/clint_regfile.sv
  - logic/clint_irq_cmp.sv
  - logic/clint_top.sv
  - target: test
    files:
      - verification/clint_checker.sv
      - verification/clint_tb.sv

//--- verification/clint_stimulus.txt
# cmd addr data expected, all hex. W write, R read, E unmapped write then read
# T pulses the RTC (data = edges), I checks timer_irq (data) and ipi (expected)
R BFF8 00000000 00000000
R 4000 00000000 FFFFFFFF
R 401C 00000000 FFFFFFFF
R 000C 00000000 00000000
I 0000 00000000 00000000
W 0004 00000001 00000000
I 0000 00000000 00000002
R 0004 00000000 00000001
W 0004 00000000 00000000
I 0000 00000000 00000000
T 0000 00000005 00000000
R BFF8 00000000 00000005
W BFF8 FFFFFFF0 00000000
W BFFC 00000001 00000000
R BFF8 00000000 FFFFFFF0
R BFFC 00000000 00000001
W 4014 00000001 00000000
W 4010 FFFFFFF4 00000000
I 0000 00000000 00000000
T 0000 00000004 00000000
I 0000 00000004 00000000
W 4010 FFFFFFF8 00000000
I 0000 00000000 00000000
E 4020 12345678 00000000
E 0002 00000001 00000000
R 4010 00000000 FFFFFFF8
I 0000 00000000 00000000
T 0000 0000000C 00000000
R BFFC 00000000 00000002
R BFF8 00000000 00000000
I 0000 00000004 00000000
